// ==== logic/rv_mem_pkg.sv ====
/*
 * RV64 integer load/store encodings, access sizes and data widths,
 * plus small decode helpers shared by the memory pipeline
 */

package rv_mem_pkg;

  localparam int xlen              = 64;
  localparam int xlen_bytes        = xlen / 8;
  localparam int byte_offset_width = $clog2(xlen_bytes);
  localparam int reg_addr_width    = 5;

  typedef enum logic [3:0] {
    e_op_lb, e_op_lbu, e_op_lh, e_op_lhu,
    e_op_lw, e_op_lwu, e_op_ld,
    e_op_sb, e_op_sh, e_op_sw, e_op_sd
  } mem_op_e;

  typedef enum logic [1:0] {
    e_size_byte, e_size_half, e_size_word, e_size_double
  } size_e;

  function automatic size_e op_size(mem_op_e op);
    size_e size;
    case (op)
      e_op_lb, e_op_lbu, e_op_sb: size = e_size_byte;
      e_op_lh, e_op_lhu, e_op_sh: size = e_size_half;
      e_op_lw, e_op_lwu, e_op_sw: size = e_size_word;
      default:                    size = e_size_double;
    endcase
    return size;
  endfunction

  function automatic logic op_is_store(mem_op_e op);
    return op inside {e_op_sb, e_op_sh, e_op_sw, e_op_sd};
  endfunction

endpackage

// ==== logic/mem_pipe_pkg.sv ====
/*
 * Pipeline payload structs, fault codes and the data memory map
 */

package mem_pipe_pkg;

  // On-chip data region, 2 KiB starting at the base
  localparam logic [rv_mem_pkg::xlen-1:0] dmem_base = 64'h0000_0000_8000_0000;
  localparam int dmem_words       = 256;
  localparam int dmem_index_width = $clog2(dmem_words);
  localparam int dmem_bytes       = dmem_words * rv_mem_pkg::xlen_bytes;

  typedef enum logic [2:0] {
    e_fault_none             = 3'd0,
    e_fault_load_misaligned  = 3'd1,
    e_fault_load_access      = 3'd2,
    e_fault_store_misaligned = 3'd3,
    e_fault_store_access     = 3'd4
  } fault_e;

  // Request after address generation
  typedef struct packed {
    rv_mem_pkg::mem_op_e                        op;
    logic [rv_mem_pkg::reg_addr_width-1:0]      rd_addr;
    logic [rv_mem_pkg::byte_offset_width-1:0]   offset;
    logic [dmem_index_width-1:0]                index;
    logic [rv_mem_pkg::xlen-1:0]                data;
    fault_e                                     fault;
  } agen_pkt_s;

  // Request after memory access; word is the raw read doubleword,
  // or the extended load result once past the aligner
  typedef struct packed {
    rv_mem_pkg::mem_op_e                        op;
    logic [rv_mem_pkg::reg_addr_width-1:0]      rd_addr;
    logic [rv_mem_pkg::byte_offset_width-1:0]   offset;
    fault_e                                     fault;
    logic [rv_mem_pkg::xlen-1:0]                word;
  } ram_pkt_s;

endpackage

// ==== logic/mem_stage_reg.sv ====
/*
 * One-entry valid/ready pipeline slot, generic over its payload type
 */

`timescale 1ns/1ns

module mem_stage_reg
  #(parameter type payload_t = logic)
  (input  logic     clk_i
   , input  logic     rst_i
   , input  logic     in_valid_i
   , input  payload_t in_data_i
   , output logic     in_ready_o
   , output logic     out_valid_o
   , output payload_t out_data_o
   , input  logic     out_ready_i
   );

  logic     full_r;
  payload_t data_r;

  // Accept when empty or when the current item leaves this cycle
  assign in_ready_o = ~full_r | out_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      full_r <= 1'b0;
    else if (in_ready_o)
      full_r <= in_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (in_valid_i && in_ready_o)
      data_r <= in_data_i;
  end

  assign out_valid_o = full_r;
  assign out_data_o  = data_r;

endmodule

// ==== logic/mem_agen.sv ====
/*
 * Effective address, access size decode, alignment and region checks
 */

`timescale 1ns/1ns

module mem_agen
  (input  rv_mem_pkg::mem_op_e                     op_i
   , input  logic [rv_mem_pkg::xlen-1:0]           rs1_i
   , input  logic [rv_mem_pkg::xlen-1:0]           imm_i
   , input  logic [rv_mem_pkg::xlen-1:0]           rs2_i
   , input  logic [rv_mem_pkg::reg_addr_width-1:0] rd_addr_i
   , output mem_pipe_pkg::agen_pkt_s               pkt_o
   );

  logic [rv_mem_pkg::xlen-1:0] eaddr;
  logic [rv_mem_pkg::xlen-1:0] rel_addr;
  rv_mem_pkg::size_e           size;
  logic                        is_store;
  logic                        misaligned;
  logic                        out_of_range;

  assign eaddr    = rs1_i + imm_i;
  assign rel_addr = eaddr - mem_pipe_pkg::dmem_base;
  assign size     = rv_mem_pkg::op_size(op_i);
  assign is_store = rv_mem_pkg::op_is_store(op_i);

  always_comb
  begin
    case (size)
      rv_mem_pkg::e_size_byte: misaligned = 1'b0;
      rv_mem_pkg::e_size_half: misaligned = eaddr[0];
      rv_mem_pkg::e_size_word: misaligned = |eaddr[1:0];
      default:                 misaligned = |eaddr[2:0];
    endcase
  end

  // Below the base wraps to a huge offset, so one compare covers both ends
  assign out_of_range = rel_addr >= mem_pipe_pkg::dmem_bytes;

  always_comb
  begin
    pkt_o.op      = op_i;
    pkt_o.rd_addr = rd_addr_i;
    pkt_o.offset  = eaddr[rv_mem_pkg::byte_offset_width-1:0];
    pkt_o.index   = rel_addr[rv_mem_pkg::byte_offset_width +: mem_pipe_pkg::dmem_index_width];
    pkt_o.data    = rs2_i;
    // Misalignment wins over access fault
    if (misaligned)
      pkt_o.fault = is_store ? mem_pipe_pkg::e_fault_store_misaligned
                             : mem_pipe_pkg::e_fault_load_misaligned;
    else if (out_of_range)
      pkt_o.fault = is_store ? mem_pipe_pkg::e_fault_store_access
                             : mem_pipe_pkg::e_fault_load_access;
    else
      pkt_o.fault = mem_pipe_pkg::e_fault_none;
  end

endmodule

// ==== logic/mem_data_ram.sv ====
/*
 * Synchronous data memory with byte-enabled stores and a result slot
 */

`timescale 1ns/1ns

module mem_data_ram
  (input  logic                       clk_i
   , input  logic                       rst_i
   , input  logic                       in_valid_i
   , input  mem_pipe_pkg::agen_pkt_s    in_pkt_i
   , output logic                       in_ready_o
   , output logic                       out_valid_o
   , output mem_pipe_pkg::ram_pkt_s     out_pkt_o
   , input  logic                       out_ready_i
   );

  logic [rv_mem_pkg::xlen-1:0]       mem [mem_pipe_pkg::dmem_words];
  logic                              full_r;
  mem_pipe_pkg::ram_pkt_s            slot_r;
  logic                              take;
  logic                              no_fault;
  logic                              is_store;
  logic [rv_mem_pkg::xlen_bytes-1:0] size_mask;
  logic [rv_mem_pkg::xlen_bytes-1:0] byte_en;
  logic [rv_mem_pkg::xlen-1:0]       wdata;

  assign in_ready_o = ~full_r | out_ready_i;
  assign take       = in_valid_i & in_ready_o;
  assign no_fault   = in_pkt_i.fault == mem_pipe_pkg::e_fault_none;
  assign is_store   = rv_mem_pkg::op_is_store(in_pkt_i.op);

  always_comb
  begin
    case (rv_mem_pkg::op_size(in_pkt_i.op))
      rv_mem_pkg::e_size_byte: size_mask = 8'h01;
      rv_mem_pkg::e_size_half: size_mask = 8'h03;
      rv_mem_pkg::e_size_word: size_mask = 8'h0f;
      default:                 size_mask = 8'hff;
    endcase
  end

  // Move store bytes into their lanes
  assign byte_en = size_mask << in_pkt_i.offset;
  assign wdata   = in_pkt_i.data << {in_pkt_i.offset, 3'b000};

  always_ff @(posedge clk_i)
  begin
    if (take && no_fault && is_store)
      for (int i = 0; i < rv_mem_pkg::xlen_bytes; i++)
      begin
        if (byte_en[i])
          mem[in_pkt_i.index][i*8 +: 8] <= wdata[i*8 +: 8];
      end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      full_r <= 1'b0;
    else if (in_ready_o)
      full_r <= in_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      slot_r.op      <= in_pkt_i.op;
      slot_r.rd_addr <= in_pkt_i.rd_addr;
      slot_r.offset  <= in_pkt_i.offset;
      slot_r.fault   <= in_pkt_i.fault;
      if (no_fault && !is_store)
        slot_r.word <= mem[in_pkt_i.index];
    end
  end

  assign out_valid_o = full_r;
  assign out_pkt_o   = slot_r;

endmodule

// ==== logic/mem_load_align.sv ====
/*
 * Load byte selection and sign/zero extension
 */

`timescale 1ns/1ns

module mem_load_align
  (input  mem_pipe_pkg::ram_pkt_s  pkt_i
   , output mem_pipe_pkg::ram_pkt_s pkt_o
   );

  logic [rv_mem_pkg::xlen-1:0] shifted;
  logic [rv_mem_pkg::xlen-1:0] ext_data;
  logic                        sign_ext;
  logic                        no_data;

  assign shifted  = pkt_i.word >> {pkt_i.offset, 3'b000};
  assign sign_ext = pkt_i.op inside {rv_mem_pkg::e_op_lb, rv_mem_pkg::e_op_lh,
                                     rv_mem_pkg::e_op_lw, rv_mem_pkg::e_op_ld};
  assign no_data  = rv_mem_pkg::op_is_store(pkt_i.op)
                  | (pkt_i.fault != mem_pipe_pkg::e_fault_none);

  always_comb
  begin
    case (rv_mem_pkg::op_size(pkt_i.op))
      rv_mem_pkg::e_size_byte:
        ext_data = {{56{sign_ext & shifted[7]}}, shifted[7:0]};
      rv_mem_pkg::e_size_half:
        ext_data = {{48{sign_ext & shifted[15]}}, shifted[15:0]};
      rv_mem_pkg::e_size_word:
        ext_data = {{32{sign_ext & shifted[31]}}, shifted[31:0]};
      default:
        ext_data = shifted;
    endcase
  end

  always_comb
  begin
    pkt_o = pkt_i;
    // Nothing to write back for stores or faults
    pkt_o.word = no_data ? '0 : ext_data;
  end

endmodule

// ==== logic/mem_pipe_top.sv ====
/*
 * Memory pipeline top: agen, stage register, data memory,
 * load aligner and response register
 */

`timescale 1ns/1ns

module mem_pipe_top
  (input  logic                                    clk_i
   , input  logic                                    rst_i
   , input  logic                                    req_valid_i
   , output logic                                    req_ready_o
   , input  rv_mem_pkg::mem_op_e                     req_op_i
   , input  logic [rv_mem_pkg::xlen-1:0]             req_rs1_i
   , input  logic [rv_mem_pkg::xlen-1:0]             req_imm_i
   , input  logic [rv_mem_pkg::xlen-1:0]             req_rs2_i
   , input  logic [rv_mem_pkg::reg_addr_width-1:0]   req_rd_addr_i
   , output logic                                    rsp_valid_o
   , input  logic                                    rsp_ready_i
   , output logic [rv_mem_pkg::xlen-1:0]             rsp_data_o
   , output logic [rv_mem_pkg::reg_addr_width-1:0]   rsp_rd_addr_o
   , output logic                                    rsp_wb_o
   , output mem_pipe_pkg::fault_e                    rsp_fault_o
   );

  mem_pipe_pkg::agen_pkt_s agen_pkt, agen_q;
  mem_pipe_pkg::ram_pkt_s  ram_pkt, align_pkt, rsp_pkt;
  logic                    agen_q_valid, ram_ready;
  logic                    ram_valid, rsp_in_ready;

  mem_agen agen
    (.op_i(req_op_i)
     , .rs1_i(req_rs1_i)
     , .imm_i(req_imm_i)
     , .rs2_i(req_rs2_i)
     , .rd_addr_i(req_rd_addr_i)
     , .pkt_o(agen_pkt)
     );

  mem_stage_reg #(.payload_t(mem_pipe_pkg::agen_pkt_s)) agen_reg
    (.clk_i(clk_i), .rst_i(rst_i)
     , .in_valid_i(req_valid_i), .in_data_i(agen_pkt), .in_ready_o(req_ready_o)
     , .out_valid_o(agen_q_valid), .out_data_o(agen_q), .out_ready_i(ram_ready)
     );

  mem_data_ram dram
    (.clk_i(clk_i), .rst_i(rst_i)
     , .in_valid_i(agen_q_valid), .in_pkt_i(agen_q), .in_ready_o(ram_ready)
     , .out_valid_o(ram_valid), .out_pkt_o(ram_pkt), .out_ready_i(rsp_in_ready)
     );

  mem_load_align align
    (.pkt_i(ram_pkt)
     , .pkt_o(align_pkt)
     );

  mem_stage_reg #(.payload_t(mem_pipe_pkg::ram_pkt_s)) rsp_reg
    (.clk_i(clk_i), .rst_i(rst_i)
     , .in_valid_i(ram_valid), .in_data_i(align_pkt), .in_ready_o(rsp_in_ready)
     , .out_valid_o(rsp_valid_o), .out_data_o(rsp_pkt), .out_ready_i(rsp_ready_i)
     );

  assign rsp_data_o    = rsp_pkt.word;
  assign rsp_rd_addr_o = rsp_pkt.rd_addr;
  assign rsp_fault_o   = rsp_pkt.fault;
  // Write back only clean loads
  assign rsp_wb_o      = ~rv_mem_pkg::op_is_store(rsp_pkt.op)
                       & (rsp_pkt.fault == mem_pipe_pkg::e_fault_none);

endmodule

// ==== verification/mem_pipe_assert.sv ====
/*
 * Concurrent checks on the response handshake, bound into the pipeline top
 */

`timescale 1ns/1ns

module mem_pipe_assert
  (input  logic                          clk_i
   , input  logic                          rst_i
   , input  logic                          rsp_valid_o
   , input  logic                          rsp_ready_i
   , input  logic [rv_mem_pkg::xlen-1:0]   rsp_data_o
   , input  logic                          rsp_wb_o
   , input  mem_pipe_pkg::fault_e          rsp_fault_o
   );

  int fail_count = 0;

  idle_after_reset: assert property (@(posedge clk_i) rst_i |=> !rsp_valid_o)
    else
    begin
      fail_count++;
      $error("rsp_valid_o high in the cycle after reset");
    end

  valid_held: assert property (@(posedge clk_i) disable iff (rst_i)
                               rsp_valid_o && !rsp_ready_i |=> rsp_valid_o)
    else
    begin
      fail_count++;
      $error("rsp_valid_o dropped while rsp_ready_i was low");
    end

  payload_held: assert property (@(posedge clk_i) disable iff (rst_i)
                                 rsp_valid_o && !rsp_ready_i
                                 |=> $stable(rsp_data_o) && $stable(rsp_fault_o))
    else
    begin
      fail_count++;
      $error("rsp_data_o or rsp_fault_o changed under back-pressure");
    end

  no_wb_on_fault: assert property (@(posedge clk_i) disable iff (rst_i)
                                   rsp_valid_o |-> !(rsp_wb_o
                                   && rsp_fault_o != mem_pipe_pkg::e_fault_none))
    else
    begin
      fail_count++;
      $error("rsp_wb_o high together with a fault");
    end

endmodule

bind mem_pipe_top mem_pipe_assert pipe_checks (.*);

// ==== verification/mem_pipe_tb.sv ====
/*
 * Memory pipeline testbench: stimulus table, shadow memory model,
 * LFSR back-pressure and in-order response checks
 */

`timescale 1ns/1ns

module mem_pipe_tb;

  localparam logic [63:0] b = mem_pipe_pkg::dmem_base;
  localparam int stall_max   = 200;
  // Response handshake lands three edges after the acceptance edge
  localparam int rsp_latency = 3;
  localparam mem_pipe_pkg::fault_e f_none = mem_pipe_pkg::e_fault_none;
  localparam mem_pipe_pkg::fault_e f_lmis = mem_pipe_pkg::e_fault_load_misaligned;
  localparam mem_pipe_pkg::fault_e f_lacc = mem_pipe_pkg::e_fault_load_access;
  localparam mem_pipe_pkg::fault_e f_smis = mem_pipe_pkg::e_fault_store_misaligned;
  localparam mem_pipe_pkg::fault_e f_sacc = mem_pipe_pkg::e_fault_store_access;

  typedef struct {
    rv_mem_pkg::mem_op_e  op;
    logic [63:0]          rs1, imm, rs2;
    logic [4:0]           rd;
    mem_pipe_pkg::fault_e fault;
  } stim_t;

  typedef struct {
    logic [63:0]          data;
    logic [4:0]           rd;
    logic                 wb;
    mem_pipe_pkg::fault_e fault;
    int                   acc_cyc;
  } exp_t;

  logic                 clk_i = 1'b0;
  logic                 rst_i, req_valid_i, req_ready_o;
  logic                 rsp_valid_o, rsp_ready_i, rsp_wb_o;
  rv_mem_pkg::mem_op_e  req_op_i;
  logic [63:0]          req_rs1_i, req_imm_i, req_rs2_i, rsp_data_o;
  logic [4:0]           req_rd_addr_i, rsp_rd_addr_o;
  mem_pipe_pkg::fault_e rsp_fault_o;
  stim_t                stim [$];
  exp_t                 exp_q [$];
  logic [7:0]           shadow [mem_pipe_pkg::dmem_bytes];
  logic [31:0]          lfsr = 32'h3c10_6226;
  int                   cyc = 0;
  int                   rsp_count = 0;

  mem_pipe_top dut (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i)
    cyc <= cyc + 1;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  function automatic int op_bytes(rv_mem_pkg::mem_op_e op);
    case (op)
      rv_mem_pkg::e_op_lb, rv_mem_pkg::e_op_lbu, rv_mem_pkg::e_op_sb: return 1;
      rv_mem_pkg::e_op_lh, rv_mem_pkg::e_op_lhu, rv_mem_pkg::e_op_sh: return 2;
      rv_mem_pkg::e_op_lw, rv_mem_pkg::e_op_lwu, rv_mem_pkg::e_op_sw: return 4;
      default: return 8;
    endcase
  endfunction

  // Stores follow the loads in the op encoding
  function automatic mem_pipe_pkg::fault_e fault_for(rv_mem_pkg::mem_op_e op,
                                                     logic [63:0] addr);
    logic st;
    st = op >= rv_mem_pkg::e_op_sb;
    if (addr % op_bytes(op) != 0)
      return st ? f_smis : f_lmis;
    if (addr < b || addr >= b + mem_pipe_pkg::dmem_bytes)
      return st ? f_sacc : f_lacc;
    return f_none;
  endfunction

  function automatic void add_req(rv_mem_pkg::mem_op_e op, logic [63:0] addr,
                                  logic [63:0] rs2, logic [4:0] rd,
                                  mem_pipe_pkg::fault_e fault);
    stim_t       s;
    logic [11:0] r;
    r = 12'(rand_bits(12));
    s.imm = {{52{r[11]}}, r};
    s.rs1 = addr - s.imm;
    s.op = op;
    s.rs2 = rs2;
    s.rd = rd;
    s.fault = fault;
    stim.push_back(s);
  endfunction

  // Expected response, applied to the shadow memory in acceptance order
  function automatic exp_t predict(stim_t s);
    exp_t        e;
    logic [63:0] addr;
    int          n;
    int          off;
    addr = s.rs1 + s.imm;
    n = op_bytes(s.op);
    off = int'(addr - b);
    e.data = '0;
    e.rd = s.rd;
    e.fault = s.fault;
    e.wb = s.op < rv_mem_pkg::e_op_sb && s.fault == f_none;
    e.acc_cyc = cyc;
    for (int k = 0; k < n && s.fault == f_none; k++)
    begin
      if (e.wb)
        e.data[8*k +: 8] = shadow[off + k];
      else
        shadow[off + k] = s.rs2[8*k +: 8];
    end
    if (e.wb && n < 8 && e.data[8*n-1] &&
        s.op inside {rv_mem_pkg::e_op_lb, rv_mem_pkg::e_op_lh, rv_mem_pkg::e_op_lw})
      e.data = e.data | (~64'h0 << (8*n));
    return e;
  endfunction

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic mismatch(string name, logic [63:0] got, logic [63:0] want);
    fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, want));
  endtask

  task automatic check_rsp();
    exp_t e;
    if (rsp_valid_o && rsp_ready_i)
    begin
      assert (exp_q.size() > 0)
        else fail_run("A response arrived with no request outstanding");
      e = exp_q.pop_front();
      if (rsp_count == 0)
        assert (cyc - e.acc_cyc == rsp_latency)
          else fail_run($sformatf("First response came %0d cycles after acceptance",
                                  cyc - e.acc_cyc));
      assert (rsp_data_o == e.data) else mismatch("rsp_data_o", rsp_data_o, e.data);
      assert (rsp_rd_addr_o == e.rd) else mismatch("rsp_rd_addr_o", rsp_rd_addr_o, e.rd);
      assert (rsp_wb_o == e.wb) else mismatch("rsp_wb_o", rsp_wb_o, e.wb);
      assert (rsp_fault_o == e.fault) else mismatch("rsp_fault_o", rsp_fault_o, e.fault);
      rsp_count++;
    end
  endtask

  task automatic present(stim_t s);
    req_valid_i   <= 1'b1;
    req_op_i      <= s.op;
    req_rs1_i     <= s.rs1;
    req_imm_i     <= s.imm;
    req_rs2_i     <= s.rs2;
    req_rd_addr_i <= s.rd;
  endtask

  initial
  begin
    int                  idx;
    int                  wait_cnt;
    logic [63:0]         a;
    rv_mem_pkg::mem_op_e op;
    rst_i = 1'b1;
    req_valid_i = 1'b0;
    req_op_i = rv_mem_pkg::e_op_ld;
    req_rs1_i = '0;
    req_imm_i = '0;
    req_rs2_i = '0;
    req_rd_addr_i = '0;
    rsp_ready_i = 1'b1;
    // Known contents in every doubleword
    for (int i = 0; i < mem_pipe_pkg::dmem_words; i++)
    begin
      a = b + 64'(8 * i);
      add_req(rv_mem_pkg::e_op_sd, a, a * 64'h9e37_79b9_7f4a_7c15, 5'(i), f_none);
    end
    // Sub-word stores merged into doublewords
    add_req(rv_mem_pkg::e_op_sd, b + 64'h100, 64'h0011_2233_4455_6677, 5'd1, f_none);
    add_req(rv_mem_pkg::e_op_sb, b + 64'h101, 64'hffff_ff9a, 5'd2, f_none);
    add_req(rv_mem_pkg::e_op_sh, b + 64'h104, 64'h1234_beef, 5'd3, f_none);
    add_req(rv_mem_pkg::e_op_sw, b + 64'h10c, 64'hdead_8765_4321, 5'd4, f_none);
    add_req(rv_mem_pkg::e_op_ld, b + 64'h100, 64'h0, 5'd5, f_none);
    add_req(rv_mem_pkg::e_op_ld, b + 64'h108, 64'h0, 5'd6, f_none);
    // Extension for each load size, top bit set and clear
    add_req(rv_mem_pkg::e_op_sd, b + 64'h200, 64'hf0e1_7f80_7001_7ffe, 5'd7, f_none);
    add_req(rv_mem_pkg::e_op_lb, b + 64'h200, 64'h0, 5'd8, f_none);
    add_req(rv_mem_pkg::e_op_lbu, b + 64'h200, 64'h0, 5'd9, f_none);
    add_req(rv_mem_pkg::e_op_lb, b + 64'h201, 64'h0, 5'd10, f_none);
    add_req(rv_mem_pkg::e_op_lh, b + 64'h206, 64'h0, 5'd11, f_none);
    add_req(rv_mem_pkg::e_op_lhu, b + 64'h206, 64'h0, 5'd12, f_none);
    add_req(rv_mem_pkg::e_op_lh, b + 64'h202, 64'h0, 5'd13, f_none);
    add_req(rv_mem_pkg::e_op_lw, b + 64'h204, 64'h0, 5'd14, f_none);
    add_req(rv_mem_pkg::e_op_lwu, b + 64'h204, 64'h0, 5'd15, f_none);
    add_req(rv_mem_pkg::e_op_lw, b + 64'h200, 64'h0, 5'd16, f_none);
    add_req(rv_mem_pkg::e_op_ld, b + 64'h200, 64'h0, 5'd17, f_none);
    // Misaligned accesses, memory rechecked afterwards
    add_req(rv_mem_pkg::e_op_lh, b + 64'h201, 64'h0, 5'd18, f_lmis);
    add_req(rv_mem_pkg::e_op_sw, b + 64'h202, 64'h1111_2222, 5'd19, f_smis);
    add_req(rv_mem_pkg::e_op_sd, b + 64'h204, 64'h3333_4444, 5'd20, f_smis);
    add_req(rv_mem_pkg::e_op_ld, b + 64'h203, 64'h0, 5'd21, f_lmis);
    add_req(rv_mem_pkg::e_op_ld, b + 64'h200, 64'h0, 5'd22, f_none);
    // Region bounds; misalignment outranks the access fault
    add_req(rv_mem_pkg::e_op_ld, b - 64'h8, 64'h0, 5'd23, f_lacc);
    add_req(rv_mem_pkg::e_op_sd, b + 64'h800, 64'h5555, 5'd24, f_sacc);
    add_req(rv_mem_pkg::e_op_lb, b + 64'h7ff, 64'h0, 5'd25, f_none);
    add_req(rv_mem_pkg::e_op_sb, b - 64'h1, 64'h66, 5'd26, f_sacc);
    add_req(rv_mem_pkg::e_op_lh, b + 64'h801, 64'h0, 5'd27, f_lmis);
    add_req(rv_mem_pkg::e_op_sw, b - 64'h2, 64'h77, 5'd28, f_smis);
    for (int i = 0; i < 64; i++)
    begin
      op = rv_mem_pkg::mem_op_e'(4'(rand_bits(4) % 11));
      a = b - 64'd32 + 64'(rand_bits(12) % 2112);
      add_req(op, a, {rand_bits(32), rand_bits(32)}, 5'(rand_bits(5)), fault_for(op, a));
    end

    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    present(stim[0]);
    idx = 0;
    wait_cnt = 0;
    while (idx < stim.size())
    begin
      @(posedge clk_i);
      check_rsp();
      if (req_ready_o)
      begin
        exp_q.push_back(predict(stim[idx]));
        idx++;
        wait_cnt = 0;
        if (idx < stim.size())
          present(stim[idx]);
        else
          req_valid_i <= 1'b0;
      end
      else
      begin
        wait_cnt++;
        if (wait_cnt > stall_max)
          fail_run("Timed out waiting for req_ready_o");
      end
      rsp_ready_i <= rsp_count == 0 || rand_bits(2) != 0;
    end

    wait_cnt = 0;
    while (exp_q.size() > 0)
    begin
      @(posedge clk_i);
      check_rsp();
      rsp_ready_i <= rand_bits(2) != 0;
      wait_cnt++;
      if (wait_cnt > stall_max)
        fail_run("Timed out waiting for the remaining responses");
    end
    // Nothing may follow the last response
    rsp_ready_i <= 1'b1;
    repeat (4)
    begin
      @(posedge clk_i);
      check_rsp();
    end

    // Fill all three stages, then reset with the items in flight
    rsp_ready_i <= 1'b0;
    present(stim[0]);
    wait_cnt = 0;
    do
    begin
      @(posedge clk_i);
      wait_cnt++;
      if (wait_cnt > stall_max)
        fail_run("Timed out filling the pipe before reset");
    end
    while (req_ready_o);
    rst_i <= 1'b1;
    req_valid_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    assert (!rsp_valid_o)
      else fail_run("rsp_valid_o still high after a reset with a full pipe");
    assert (req_ready_o)
      else fail_run("req_ready_o low after a reset with a full pipe");

    if (dut.pipe_checks.fail_count == 0)
    begin
      $display("sim passed");
      $finish;
    end
    else
      fail_run("A bound assertion on the response port failed");
  end

endmodule

// ==== src.f ====
logic/rv_mem_pkg.sv
logic/mem_pipe_pkg.sv
logic/mem_stage_reg.sv
logic/mem_agen.sv
logic/mem_data_ram.sv
logic/mem_load_align.sv
logic/mem_pipe_top.sv
verification/mem_pipe_assert.sv
verification/mem_pipe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module mem_pipe_tb \
    -f src.f -o mem_pipe_sim; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/mem_pipe_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" <<< "$output"; then
  exit 0
fi
exit 1
